// ==== logic/div_pkg.sv ====
package div_pkg;

    // #########################################################################
    // Word sizes
    // #########################################################################

    localparam int reg_size  = 32;         // Processor register and dividend width.
    localparam int half_size = 16;         // Divisor, quotient and remainder width.

    // #########################################################################
    // Request tagging
    // #########################################################################

    // The tag names the destination register of the result.
    localparam int tag_width = 5;          // Enough for a 32-entry register file.

    // #########################################################################
    // Restoring loop
    // #########################################################################

    // One quotient bit is produced per step.
    localparam int div_steps = 16;         // Equal to half_size.

    localparam int step_cnt_width = 5;     // Must hold the value div_steps itself.

endpackage

// ==== logic/restoring_divider.sv ====
`timescale 1ns/100ps

module restoring_divider
    import div_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  logic [reg_size-1:0]  dividend,
    input  logic [half_size-1:0] divisor,
    output logic [half_size-1:0] quotient,
    output logic [half_size-1:0] remainder,
    output logic                 running,
    output logic                 finish
);

    // #########################################################################
    // Registers
    // #########################################################################

    logic [half_size-1:0]      partial_rem;   // Upper half, ends as the remainder.
    logic [half_size-1:0]      shift_reg;     // Dividend low half, ends as the quotient.
    logic [half_size-1:0]      divisor_reg;
    logic [step_cnt_width-1:0] step_cnt;
    logic                      running_reg;

    // #########################################################################
    // One restoring step
    // #########################################################################

    logic [half_size-1:0] shifted;            // Partial remainder shifted left by one.
    logic                 carry_top;          // Bit pushed out of the top by the shift.
    logic [half_size:0]   diff;               // Difference with a borrow bit on top.
    logic                 q_bit;
    logic [half_size-1:0] next_rem;

    always_comb begin
        shifted   = {partial_rem[half_size-2:0], shift_reg[half_size-1]};
        carry_top = partial_rem[half_size-1];
        diff      = {1'b0, shifted} - {1'b0, divisor_reg};

        // With the carried-out bit set, the true shifted value is at least 2^16
        // and so always exceeds the divisor, whatever the borrow says.
        q_bit = carry_top || !diff[half_size];

        if (q_bit) begin
            next_rem = diff[half_size-1:0];   // Keep the difference.
        end else begin
            next_rem = shifted;               // Restore the shifted value.
        end
    end

    // #########################################################################
    // Step control
    // #########################################################################

    always_ff @(posedge clk) begin
        if (reset) begin
            running_reg <= 1'b0;
            step_cnt    <= '0;
        end else if (start) begin
            running_reg <= 1'b1;              // Steps begin on the next edge.
            step_cnt    <= '0;
        end else if (running_reg) begin
            step_cnt <= step_cnt + 1'b1;
            if (step_cnt == step_cnt_width'(div_steps - 1)) begin
                running_reg <= 1'b0;          // This edge performs the last step.
            end
        end else if (finish) begin
            step_cnt <= '0;                   // Ends the finish pulse.
        end
    end

    // Operands are loaded on the start edge and then shifted once per step.
    always_ff @(posedge clk) begin
        if (start) begin
            partial_rem <= dividend[reg_size-1:half_size];
            shift_reg   <= dividend[half_size-1:0];
            divisor_reg <= divisor;
        end else if (running_reg) begin
            partial_rem <= next_rem;
            shift_reg   <= {shift_reg[half_size-2:0], q_bit};
        end
    end

    assign running   = running_reg;
    assign finish    = (step_cnt == step_cnt_width'(div_steps));  // Cycle after step 16.
    assign quotient  = shift_reg;
    assign remainder = partial_rem;

endmodule

// ==== logic/div_request_ctrl.sv ====
`timescale 1ns/100ps

module div_request_ctrl
    import div_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req,
    input  logic                 op_rem,
    input  logic [reg_size-1:0]  dividend,
    input  logic [half_size-1:0] divisor,
    input  logic [tag_width-1:0] tag,
    output logic                 start,
    input  logic [half_size-1:0] quotient,
    input  logic [half_size-1:0] remainder,
    input  logic                 finish,
    output logic                 busy,
    output logic                 done,
    output logic                 req_dropped,
    output logic                 div_by_zero,
    output logic                 overflow,
    output logic [reg_size-1:0]  result,
    output logic [tag_width-1:0] result_tag
);

    // #########################################################################
    // Exception checks on the incoming request
    // #########################################################################

    logic zero_divisor;
    logic quot_overflow;
    logic accept;

    assign zero_divisor = (divisor == '0);

    // The quotient fits in half_size bits only when the upper dividend half
    // is strictly below the divisor.
    assign quot_overflow = !zero_divisor &&
                           (dividend[reg_size-1:half_size] >= divisor);

    // #########################################################################
    // Two-state FSM, idle or waiting for the divider
    // #########################################################################

    logic                 waiting;
    logic                 op_rem_reg;         // Selection held while the divider runs.
    logic [tag_width-1:0] tag_reg;            // Tag held while the divider runs.

    assign busy   = waiting || done;          // The done cycle still counts as busy.
    assign accept = req && !busy;
    assign start  = accept && !zero_divisor && !quot_overflow;

    always_ff @(posedge clk) begin
        if (reset) begin
            waiting     <= 1'b0;
            done        <= 1'b0;
            req_dropped <= 1'b0;
            div_by_zero <= 1'b0;
            overflow    <= 1'b0;
            result      <= '0;
            result_tag  <= '0;
        end else begin
            done        <= 1'b0;
            div_by_zero <= 1'b0;              // Error flags pulse together with done.
            overflow    <= 1'b0;
            req_dropped <= req && busy;

            if (accept) begin
                if (zero_divisor || quot_overflow) begin
                    // Complete at once and leave the divider idle.
                    done        <= 1'b1;
                    div_by_zero <= zero_divisor;
                    overflow    <= quot_overflow;
                    result      <= '0;
                    result_tag  <= tag;
                end else begin
                    waiting <= 1'b1;
                end
            end else if (waiting && finish) begin
                waiting    <= 1'b0;
                done       <= 1'b1;
                result_tag <= tag_reg;
                if (op_rem_reg) begin
                    result <= {{(reg_size - half_size){1'b0}}, remainder};
                end else begin
                    result <= {{(reg_size - half_size){1'b0}}, quotient};
                end
            end
        end
    end

    // #########################################################################
    // Request fields kept for the completion
    // #########################################################################

    always_ff @(posedge clk) begin
        if (start) begin
            op_rem_reg <= op_rem;
            tag_reg    <= tag;
        end
    end

endmodule

// ==== logic/div_unit.sv ====
`timescale 1ns/100ps

module div_unit
    import div_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req,
    input  logic                 op_rem,
    input  logic [reg_size-1:0]  dividend,
    input  logic [half_size-1:0] divisor,
    input  logic [tag_width-1:0] tag,
    output logic                 done,
    output logic                 busy,
    output logic                 req_dropped,
    output logic                 div_by_zero,
    output logic                 overflow,
    output logic [reg_size-1:0]  result,
    output logic [tag_width-1:0] result_tag
);

    // #########################################################################
    // Controller to divider wiring
    // #########################################################################

    logic                 div_start;
    logic                 div_finish;
    logic [half_size-1:0] div_quotient;
    logic [half_size-1:0] div_remainder;

    div_request_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .op_rem      (op_rem),
        .dividend    (dividend),
        .divisor     (divisor),
        .tag         (tag),
        .start       (div_start),
        .quotient    (div_quotient),
        .remainder   (div_remainder),
        .finish      (div_finish),
        .busy        (busy),
        .done        (done),
        .req_dropped (req_dropped),
        .div_by_zero (div_by_zero),
        .overflow    (overflow),
        .result      (result),
        .result_tag  (result_tag)
    );

    // The divider takes its operands straight from the request inputs, so
    // they are loaded on the same edge that accepts the request.
    restoring_divider u_divider (
        .clk       (clk),
        .reset     (reset),
        .start     (div_start),
        .dividend  (dividend),
        .divisor   (divisor),
        .quotient  (div_quotient),
        .remainder (div_remainder),
        .running   (),                        // The controller tracks busy by itself.
        .finish    (div_finish)
    );

endmodule

// ==== tb/div_unit_chk.sv ====
`timescale 1ns/100ps

module div_unit_chk (
    input logic clk,
    input logic reset,
    input logic req,
    input logic busy,
    input logic done,
    input logic req_dropped,
    input logic div_by_zero,
    input logic overflow
);

    // #########################################################################
    // Result strobe
    // #########################################################################

    // No back-pressure exists, so done never stretches over two cycles.
    assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("done stayed high for more than one cycle.");

    // #########################################################################
    // Error flags
    // #########################################################################

    assert property (@(posedge clk) disable iff (reset) !(div_by_zero && overflow))
        else $error("div_by_zero and overflow were high together.");

    assert property (@(posedge clk) disable iff (reset) (div_by_zero || overflow) |-> done)
        else $error("An error flag was high without done.");

    // #########################################################################
    // Dropped requests
    // #########################################################################

    assert property (@(posedge clk) disable iff (reset) req_dropped |-> $past(req && busy))
        else $error("req_dropped rose without a request sampled while busy.");

endmodule

bind div_unit div_unit_chk u_chk (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .busy        (busy),
    .done        (done),
    .req_dropped (req_dropped),
    .div_by_zero (div_by_zero),
    .overflow    (overflow)
);

// ==== tb/div_unit_tb.sv ====
`timescale 1ns/100ps

module div_unit_tb
    import div_pkg::*;
();

    localparam int done_timeout = 40;         // Cycles allowed from request to done.

    logic                 clk;
    logic                 reset;
    logic                 req;
    logic                 op_rem;
    logic [reg_size-1:0]  dividend;
    logic [half_size-1:0] divisor;
    logic [tag_width-1:0] tag;
    logic                 done;
    logic                 busy;
    logic                 req_dropped;
    logic                 div_by_zero;
    logic                 overflow;
    logic [reg_size-1:0]  result;
    logic [tag_width-1:0] result_tag;

    int check_count;
    int error_count;

    // Values captured in the cycle in which done was seen.
    logic                 got_done;
    logic [reg_size-1:0]  got_result;
    logic [tag_width-1:0] got_tag;
    logic                 got_dbz;
    logic                 got_ovf;

    logic [31:0] lcg_state;

    div_unit UUT (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .op_rem      (op_rem),
        .dividend    (dividend),
        .divisor     (divisor),
        .tag         (tag),
        .done        (done),
        .busy        (busy),
        .req_dropped (req_dropped),
        .div_by_zero (div_by_zero),
        .overflow    (overflow),
        .result      (result),
        .result_tag  (result_tag)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                // 10 ns period.
    end

    // #########################################################################
    // Helpers
    // #########################################################################

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic compare(input string test_name, input string what,
                           input logic [31:0] expected, input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("[FAIL] %s: %s expected 0x%08h, actual 0x%08h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic drive_request(input logic [reg_size-1:0] dvd, input logic [half_size-1:0] dvs,
                                 input logic rem, input logic [tag_width-1:0] t);
        req      = 1'b1;
        dividend = dvd;
        divisor  = dvs;
        op_rem   = rem;
        tag      = t;
    endtask

    // Sends one request and waits for its done strobe.
    task automatic issue_request(input string test_name, input logic [reg_size-1:0] dvd,
                                 input logic [half_size-1:0] dvs, input logic rem,
                                 input logic [tag_width-1:0] t);
        int cycles;
        cycles   = 0;
        got_done = 1'b0;
        @(posedge clk);
        #1;
        drive_request(dvd, dvs, rem, t);
        while (!got_done && cycles < done_timeout) begin
            @(posedge clk);
            #1;
            req = 1'b0;                       // The strobe lasts one cycle.
            cycles++;
            if (done) begin
                got_done   = 1'b1;
                got_result = result;
                got_tag    = result_tag;
                got_dbz    = div_by_zero;
                got_ovf    = overflow;
            end
        end
        if (!got_done) begin
            error_count++;
            $display("Timeout in test %s: no done within %0d cycles of the request.",
                     test_name, done_timeout);
        end
    endtask

    // Works out the expected response from the unit's rules and checks it.
    task automatic check_division(input string test_name, input logic [reg_size-1:0] dvd,
                                  input logic [half_size-1:0] dvs, input logic rem,
                                  input logic [tag_width-1:0] t);
        logic                exp_dbz;
        logic                exp_ovf;
        logic [reg_size-1:0] exp_quot;
        logic [reg_size-1:0] exp_result;
        exp_dbz    = (dvs == '0);
        exp_ovf    = 1'b0;
        exp_result = '0;
        if (!exp_dbz) begin
            exp_quot = dvd / reg_size'(dvs);
            exp_ovf  = ((exp_quot >> half_size) != '0);  // The quotient needs more than 16 bits.
            if (!exp_ovf) begin
                if (rem) begin
                    exp_result = dvd % reg_size'(dvs);
                end else begin
                    exp_result = exp_quot;
                end
            end
        end
        issue_request(test_name, dvd, dvs, rem, t);
        compare(test_name, "done seen", 32'(1'b1), 32'(got_done));
        compare(test_name, "result", exp_result, got_result);
        compare(test_name, "result_tag", 32'(t), 32'(got_tag));
        compare(test_name, "div_by_zero", 32'(exp_dbz), 32'(got_dbz));
        compare(test_name, "overflow", 32'(exp_ovf), 32'(got_ovf));
    endtask

    task automatic finish_test(input string test_name, input int errors_before);
        $display("Test %s finished with %0d errors.", test_name, error_count - errors_before);
    endtask

    // #########################################################################
    // Tests
    // #########################################################################

    task automatic run_fixed_set(input string test_name, input logic rem);
        logic [tag_width-1:0] base;
        base = rem ? tag_width'(16) : tag_width'(0);  // Different tags per operation.
        check_division(test_name, 32'd100, 16'd7, rem, base + tag_width'(1));
        check_division(test_name, 32'h1234_5678, 16'hABCD, rem, base + tag_width'(2));
        check_division(test_name, 32'h0000_FFFF, 16'd1, rem, base + tag_width'(3));
        check_division(test_name, 32'd5, 16'd9, rem, base + tag_width'(4));
        check_division(test_name, 32'h0000_0000, 16'd3, rem, base + tag_width'(5));
    endtask

    task automatic test_quotient();
        int errors_before;
        errors_before = error_count;
        run_fixed_set("quotient", 1'b0);
        finish_test("quotient", errors_before);
    endtask

    task automatic test_remainder();
        int errors_before;
        errors_before = error_count;
        run_fixed_set("remainder", 1'b1);
        finish_test("remainder", errors_before);
    endtask

    task automatic test_divide_by_zero();
        int errors_before;
        errors_before = error_count;
        check_division("divide_by_zero", 32'd1234, 16'd0, 1'b0, 5'd9);
        check_division("divide_by_zero", 32'hFFFF_FFFF, 16'd0, 1'b1, 5'd10);
        check_division("divide_by_zero", 32'd1000, 16'd10, 1'b0, 5'd11);  // Recovery.
        finish_test("divide_by_zero", errors_before);
    endtask

    task automatic test_overflow_boundary();
        int errors_before;
        errors_before = error_count;
        check_division("overflow_boundary", 32'h0040_0000, 16'h0040, 1'b0, 5'd20);
        check_division("overflow_boundary", 32'h003F_FFFF, 16'h0040, 1'b0, 5'd21);
        check_division("overflow_boundary", 32'hFFFF_0000, 16'hFFFF, 1'b0, 5'd22);
        check_division("overflow_boundary", 32'hFFFE_FFFF, 16'hFFFF, 1'b0, 5'd23);
        check_division("overflow_boundary", 32'hFFFE_FFFF, 16'hFFFF, 1'b1, 5'd24);
        finish_test("overflow_boundary", errors_before);
    endtask

    task automatic test_random();
        int                   errors_before;
        logic [half_size-1:0] dvs;
        logic [half_size-1:0] upper;
        logic [reg_size-1:0]  dvd;
        logic                 rem;
        logic [tag_width-1:0] t;
        errors_before = error_count;
        lcg_state     = 32'd25397;
        for (int i = 0; i < 50; i++) begin
            lcg_state = lcg_next(lcg_state);
            dvs       = lcg_state[31:16];
            if (dvs == '0) begin
                dvs = 16'd1;
            end
            lcg_state = lcg_next(lcg_state);
            upper     = lcg_state[31:16] % dvs;   // Keeps the quotient within 16 bits.
            lcg_state = lcg_next(lcg_state);
            dvd       = {upper, lcg_state[31:16]};
            rem       = lcg_state[15];
            t         = lcg_state[12:8];
            check_division("random", dvd, dvs, rem, t);
        end
        finish_test("random", errors_before);
    endtask

    task automatic test_busy_drop();
        int errors_before;
        int done_count;
        logic [reg_size-1:0]  first_result;
        logic [tag_width-1:0] first_tag;
        errors_before = error_count;
        done_count    = 0;
        first_result  = '0;
        first_tag     = '0;
        @(posedge clk);
        #1;
        drive_request(32'h0005_4321, 16'h0100, 1'b0, 5'd7);
        @(posedge clk);
        #1;
        compare("busy_drop", "busy", 32'(1'b1), 32'(busy));
        drive_request(32'h0000_0010, 16'd2, 1'b0, 5'd12);  // Arrives while busy.
        @(posedge clk);
        #1;
        req = 1'b0;
        compare("busy_drop", "req_dropped", 32'(1'b1), 32'(req_dropped));
        if (done) begin
            done_count++;
        end
        for (int i = 0; i < done_timeout; i++) begin
            @(posedge clk);
            #1;
            if (done) begin
                done_count++;
                first_result = result;
                first_tag    = result_tag;
            end
        end
        if (done_count == 0) begin
            error_count++;
            $display("Timeout in test busy_drop: no done within %0d cycles.", done_timeout);
        end
        compare("busy_drop", "done count", 32'd1, 32'(done_count));
        compare("busy_drop", "result", 32'h0005_4321 / 32'h0000_0100, first_result);
        compare("busy_drop", "result_tag", 32'd7, 32'(first_tag));
        finish_test("busy_drop", errors_before);
    endtask

    // #########################################################################
    // Main sequence
    // #########################################################################

    initial begin
        check_count = 0;
        error_count = 0;
        got_done    = 1'b0;
        got_result  = '0;
        got_tag     = '0;
        got_dbz     = 1'b0;
        got_ovf     = 1'b0;
        lcg_state   = 32'd25397;
        reset       = 1'b1;
        req         = 1'b0;
        op_rem      = 1'b0;
        dividend    = '0;
        divisor     = '0;
        tag         = '0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        test_quotient();
        test_remainder();
        test_divide_by_zero();
        test_overflow_boundary();
        test_random();
        test_busy_drop();

        $display("Summary: %0d checks, %0d errors.", check_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
logic/div_pkg.sv
logic/restoring_divider.sv
logic/div_request_ctrl.sv
logic/div_unit.sv
tb/div_unit_chk.sv
tb/div_unit_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module div_unit_tb -f compile.f -Mdir obj_dir

run: compile
	./obj_dir/Vdiv_unit_tb > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Failure reported in $(LOG)"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "No pass line in $(LOG)"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)
